/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := fetch_buffer_tb
FILELIST  := fetch_buffer.f
BUILD_DIR := obj_dir
SIM_ARGS  := +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@output="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$output"; \
	echo "$$output" | grep -qxF '** PASS **'

clean:
	rm -rf $(BUILD_DIR)

/* fetch_buffer.f */
logic/fetch_buffer_pkg.sv
logic/halfword_bank.sv
logic/buffer_pointers.sv
logic/instr_extract.sv
logic/fetch_buffer.sv
verif/tb_clock_gen.sv
verif/fetch_buffer_props.sv
verif/fetch_buffer_tb.sv

/* logic/buffer_pointers.sv */
`default_nettype none

module buffer_pointers
  import fetch_buffer_pkg::*;
#(
  parameter int buffer_depth = 8
) (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            clear,
  input  logic                            fetch_valid,
  input  pc_t                             fetch_pc,
  input  logic [2:0]                      consumed,
  output logic                            write_enable,
  output logic [$clog2(buffer_depth)-1:0] write_addr,
  output logic [$clog2(buffer_depth)-1:0] read_addr0,
  output logic [$clog2(buffer_depth)-1:0] read_addr1,
  output logic [$clog2(buffer_depth)-1:0] read_addr2,
  output logic [$clog2(buffer_depth)-1:0] read_addr3,
  output logic [1:0]                      rotation,
  output logic [2:0]                      available,
  output logic                            fetch_stall
);

  localparam int addr_width  = $clog2(buffer_depth);
  localparam int ptr_width   = addr_width + 2;
  localparam int count_width = addr_width + 3;
  localparam int threshold   = bank_count * (buffer_depth - 2);

  logic [addr_width-1:0]  write_ptr;  // Counts rows, one block of bank_count halfwords each.
  logic [ptr_width-1:0]   read_ptr;   // Halfword granular.
  logic [count_width-1:0] occupancy;
  logic                   clear_flag;
  logic                   full_flag;

  logic                   realign;
  logic [1:0]             skip;
  logic [count_width-1:0] incoming;
  logic [ptr_width-1:0]   read_now;
  logic [addr_width-1:0]  read_row;
  logic [addr_width-1:0]  read_row_next;
  logic [count_width-1:0] count_now;
  logic [count_width-1:0] occupancy_next;

  assign write_enable = fetch_valid & ~clear & ~full_flag;
  assign fetch_stall  = ~write_enable;

  // First block after a redirect drops the halfwords below its PC.
  assign realign  = clear_flag & write_enable;
  assign skip     = realign ? fetch_pc[2:1] : 2'b00;
  assign incoming = write_enable ? count_width'(bank_count) : '0;

  // Low pointer bits are zero after clear, so adding the skip is enough.
  assign read_now      = read_ptr + ptr_width'(skip);
  assign read_row      = read_now[ptr_width-1:2];
  assign read_row_next = read_row + 1'b1;
  assign rotation      = read_now[1:0];

  assign write_addr = write_ptr;

  // Banks below the rotation already wrapped into the next row.
  assign read_addr0 = (rotation > 2'd0) ? read_row_next : read_row;
  assign read_addr1 = (rotation > 2'd1) ? read_row_next : read_row;
  assign read_addr2 = (rotation > 2'd2) ? read_row_next : read_row;
  assign read_addr3 = read_row;

  // Includes the block being written this cycle.
  assign count_now = clear ? '0 : occupancy + incoming - count_width'(skip);

  // Two instructions never need more than four halfwords.
  assign available = (count_now > count_width'(4)) ? 3'd4 : count_now[2:0];

  assign occupancy_next = count_now - count_width'(consumed);

  always_ff @(posedge clock) begin
    if (!reset) begin
      write_ptr  <= '0;
      read_ptr   <= '0;
      occupancy  <= '0;
      clear_flag <= 1'b1;  // Reset behaves like a redirect.
      full_flag  <= 1'b0;
    end else if (clear) begin
      write_ptr  <= '0;
      read_ptr   <= '0;
      occupancy  <= '0;
      clear_flag <= 1'b1;
      full_flag  <= 1'b0;
    end else begin
      if (write_enable) begin
        write_ptr  <= write_ptr + 1'b1;
        clear_flag <= 1'b0;
      end
      read_ptr  <= read_now + ptr_width'(consumed);
      occupancy <= occupancy_next;
      full_flag <= occupancy_next > count_width'(threshold);
    end
  end

endmodule

`default_nettype wire

/* logic/fetch_buffer.sv */
`default_nettype none

module fetch_buffer
  import fetch_buffer_pkg::*;
#(
  parameter int buffer_depth = 8
) (
  input  logic   clock,
  input  logic   reset,
  input  logic   clear,
  input  logic   fetch_valid,
  input  logic   hold,
  input  pc_t    fetch_pc,
  input  block_t fetch_data,
  output logic   fetch_stall,
  output logic   valid0,
  output logic   valid1,
  output pc_t    pc0,
  output pc_t    pc1,
  output instr_t instr0,
  output instr_t instr1
);

  localparam int addr_width = $clog2(buffer_depth);

  logic                  write_enable;
  logic [addr_width-1:0] write_addr;
  logic [addr_width-1:0] read_addr    [bank_count];
  halfword_t             fetch_parcel [bank_count];
  entry_t                write_entry  [bank_count];
  entry_t                read_entry   [bank_count];
  logic [1:0]            rotation;
  logic [2:0]            available;
  logic [2:0]            consumed;

  for (genvar k = 0; k < bank_count; k++) begin : g_bank
    assign fetch_parcel[k] = fetch_data[$bits(halfword_t)*k +: $bits(halfword_t)];
    // Block PC with the low bits set to this slot's offset.
    assign write_entry[k]  = {fetch_pc[31:3], 3'(2 * k), fetch_parcel[k]};

    halfword_bank #(
      .buffer_depth (buffer_depth)
    ) bank_inst (
      .clock        (clock),
      .write_enable (write_enable),
      .write_addr   (write_addr),
      .write_entry  (write_entry[k]),
      .read_addr    (read_addr[k]),
      .read_entry   (read_entry[k])
    );
  end

  buffer_pointers #(
    .buffer_depth (buffer_depth)
  ) pointers_inst (
    .clock        (clock),
    .reset        (reset),
    .clear        (clear),
    .fetch_valid  (fetch_valid),
    .fetch_pc     (fetch_pc),
    .consumed     (consumed),
    .write_enable (write_enable),
    .write_addr   (write_addr),
    .read_addr0   (read_addr[0]),
    .read_addr1   (read_addr[1]),
    .read_addr2   (read_addr[2]),
    .read_addr3   (read_addr[3]),
    .rotation     (rotation),
    .available    (available),
    .fetch_stall  (fetch_stall)
  );

  instr_extract extract_inst (
    .entry0    (read_entry[0]),
    .entry1    (read_entry[1]),
    .entry2    (read_entry[2]),
    .entry3    (read_entry[3]),
    .rotation  (rotation),
    .available (available),
    .hold      (hold),
    .consumed  (consumed),
    .valid0    (valid0),
    .valid1    (valid1),
    .pc0       (pc0),
    .pc1       (pc1),
    .instr0    (instr0),
    .instr1    (instr1)
  );

endmodule

`default_nettype wire

/* logic/fetch_buffer_pkg.sv */
`default_nettype none

package fetch_buffer_pkg;

  typedef logic [31:0] pc_t;
  typedef logic [15:0] halfword_t;

  // Halfword PC in the upper bits, the parcel in the lower 16.
  typedef logic [$bits(pc_t)+$bits(halfword_t)-1:0] entry_t;

  typedef logic [31:0] instr_t;  // Compressed ones are zero-extended.
  typedef logic [63:0] block_t;  // Halfword 0 in the low bits.

  localparam int bank_count = 4;  // Halfwords per fetch block.

  localparam pc_t invalid_pc = 32'hffff_ffff;  // Shown on an empty issue slot.

endpackage

`default_nettype wire

/* logic/halfword_bank.sv */
`default_nettype none

module halfword_bank
  import fetch_buffer_pkg::*;
#(
  parameter int buffer_depth = 8
) (
  input  logic                            clock,
  input  logic                            write_enable,
  input  logic [$clog2(buffer_depth)-1:0] write_addr,
  input  entry_t                          write_entry,
  input  logic [$clog2(buffer_depth)-1:0] read_addr,
  output entry_t                          read_entry
);

  entry_t storage [buffer_depth];

  always_ff @(posedge clock) begin
    if (write_enable) begin
      storage[write_addr] <= write_entry;
    end
  end

  // A block written this cycle is visible at once.
  assign read_entry = (write_enable && (write_addr == read_addr)) ? write_entry
                                                                   : storage[read_addr];

endmodule

`default_nettype wire

/* logic/instr_extract.sv */
`default_nettype none

module instr_extract
  import fetch_buffer_pkg::*;
(
  input  entry_t     entry0,
  input  entry_t     entry1,
  input  entry_t     entry2,
  input  entry_t     entry3,
  input  logic [1:0] rotation,
  input  logic [2:0] available,
  input  logic       hold,
  output logic [2:0] consumed,
  output logic       valid0,
  output logic       valid1,
  output pc_t        pc0,
  output pc_t        pc1,
  output instr_t     instr0,
  output instr_t     instr1
);

  entry_t     bank_entry [bank_count];
  halfword_t  parcel     [bank_count];  // In program order.
  pc_t        parcel_pc  [bank_count];
  logic       compressed [bank_count];

  logic [2:0] first_len;
  logic [1:0] second_start;
  logic [1:0] second_upper;
  logic [2:0] second_len;

  assign bank_entry[0] = entry0;
  assign bank_entry[1] = entry1;
  assign bank_entry[2] = entry2;
  assign bank_entry[3] = entry3;

  for (genvar slot = 0; slot < bank_count; slot++) begin : g_order
    logic [1:0] bank_sel;

    assign bank_sel         = rotation + 2'(slot);
    assign parcel[slot]     = bank_entry[bank_sel][$bits(halfword_t)-1:0];
    assign parcel_pc[slot]  = bank_entry[bank_sel][$bits(entry_t)-1:$bits(halfword_t)];
    assign compressed[slot] = ~&parcel[slot][1:0];  // 32-bit only when both low bits set.
  end

  assign first_len    = compressed[0] ? 3'd1 : 3'd2;
  assign second_start = first_len[1:0];
  assign second_upper = second_start + 2'd1;
  assign second_len   = compressed[second_start] ? 3'd1 : 3'd2;

  always_comb begin
    valid0   = 1'b0;
    valid1   = 1'b0;
    pc0      = invalid_pc;
    pc1      = invalid_pc;
    instr0   = '0;
    instr1   = '0;
    consumed = '0;

    // Slot 1 is only looked at once slot 0 issues.
    if (!hold && (available >= first_len)) begin
      valid0   = 1'b1;
      pc0      = parcel_pc[0];
      instr0   = compressed[0] ? {16'h0000, parcel[0]} : {parcel[1], parcel[0]};
      consumed = first_len;

      if (available >= first_len + second_len) begin
        valid1 = 1'b1;
        pc1    = parcel_pc[second_start];
        if (compressed[second_start]) begin
          instr1 = {16'h0000, parcel[second_start]};
        end else begin
          instr1 = {parcel[second_upper], parcel[second_start]};
        end
        consumed = first_len + second_len;
      end
    end
  end

endmodule

`default_nettype wire

/* verif/fetch_buffer_props.sv */
`default_nettype none

module fetch_buffer_props
  import fetch_buffer_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic hold,
  input logic valid0,
  input logic valid1,
  input pc_t  pc0
);
  timeunit 1ns;
  timeprecision 1ps;

  slot_order: assert property (@(posedge clock) disable iff (!reset) valid1 |-> valid0)
    else $error("valid1 high while valid0 is low");

  empty_slot_pc: assert property (@(posedge clock) disable iff (!reset)
    !valid0 |-> (pc0 == invalid_pc))
    else $error("pc0 differs from invalid_pc on an empty slot");

  // Decode back-pressure blocks both slots.
  hold_blocks_issue: assert property (@(posedge clock) disable iff (!reset)
    hold |-> (!valid0 && !valid1))
    else $error("an instruction issued while hold is high");

endmodule

`default_nettype wire

/* verif/fetch_buffer_tb.sv */
`default_nettype none

module fetch_buffer_tb
  import fetch_buffer_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int buffer_depth = 8;
  localparam int threshold    = 4 * (buffer_depth - 2);  // Halfwords.

  // Cycle bound per test including the worst-case drain.
  localparam int compressed_cycles = 12;
  localparam int mixed_cycles      = 28;
  localparam int realign_cycles    = 12;
  localparam int hold_cycles       = 14;
  localparam int stall_cycles      = 36;
  localparam int timeout_cycles    = 2 * (compressed_cycles + mixed_cycles + realign_cycles
                                          + hold_cycles + stall_cycles) + 2;

  logic   clock;
  logic   reset;
  logic   clear;
  logic   fetch_valid;
  logic   hold;
  pc_t    fetch_pc;
  block_t fetch_data;
  logic   fetch_stall;
  logic   valid0;
  logic   valid1;
  pc_t    pc0;
  pc_t    pc1;
  instr_t instr0;
  instr_t instr1;

  entry_t      model_queue [$];  // PC-tagged halfwords in program order.
  logic        model_full      = 1'b0;
  logic        realign_pending = 1'b1;
  logic        last_accepted   = 1'b0;
  logic [31:0] lfsr_state      = 32'd71240;
  int          error_count     = 0;
  int          check_count     = 0;
  int          cycle_count     = 0;

  tb_clock_gen #(.reset_cycles(2)) clock_gen_inst (.clock(clock), .reset(reset));

  fetch_buffer #(
    .buffer_depth (buffer_depth)
  ) fetch_buffer_inst (
    .clock       (clock),
    .reset       (reset),
    .clear       (clear),
    .fetch_valid (fetch_valid),
    .hold        (hold),
    .fetch_pc    (fetch_pc),
    .fetch_data  (fetch_data),
    .fetch_stall (fetch_stall),
    .valid0      (valid0),
    .valid1      (valid1),
    .pc0         (pc0),
    .pc1         (pc1),
    .instr0      (instr0),
    .instr1      (instr1)
  );

  bind fetch_buffer fetch_buffer_props props_inst (
    .clock  (clock),
    .reset  (reset),
    .hold   (hold),
    .valid0 (valid0),
    .valid1 (valid1),
    .pc0    (pc0)
  );

  task automatic check_valid(input string name, input logic actual, input logic expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic check_pc(input string name, input pc_t actual, input pc_t expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic check_instr(input string name, input instr_t actual, input instr_t expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];  // x^32 + x^22 + x^2 + x + 1.
    return {state[30:0], feedback};
  endfunction

  task automatic random_block(output block_t block);
    for (int i = 0; i < 64; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      block[i]   = lfsr_state[0];
    end
  endtask

  function automatic block_t compressed_block(input pc_t pc);
    block_t block;
    for (int k = 0; k < 4; k++) begin
      block[16*k +: 16] = {pc[11:0] + 12'(2 * k), 4'h4};  // Low bits 00.
    end
    return block;
  endfunction

  function automatic pc_t entry_pc(input entry_t entry);
    return entry[47:16];
  endfunction

  function automatic halfword_t entry_hw(input entry_t entry);
    return entry[15:0];
  endfunction

  function automatic int instr_length(input halfword_t hw);
    return (hw[1:0] == 2'b11) ? 2 : 1;
  endfunction

  function automatic logic issue_pending();
    if (model_queue.size() == 0) begin
      return 1'b0;
    end
    return model_queue.size() >= instr_length(entry_hw(model_queue[0]));
  endfunction

  task automatic predict_slot(input logic enable, input int start, output logic valid,
                              output pc_t pc, output instr_t instr, output int used);
    int length;
    valid = 1'b0;
    pc    = invalid_pc;
    instr = '0;
    used  = 0;
    if (enable && (start < model_queue.size())) begin
      length = instr_length(entry_hw(model_queue[start]));
      if (model_queue.size() - start >= length) begin
        valid = 1'b1;
        pc    = entry_pc(model_queue[start]);
        if (length == 1) begin
          instr = {16'h0000, entry_hw(model_queue[start])};
        end else begin
          instr = {entry_hw(model_queue[start+1]), entry_hw(model_queue[start])};
        end
        used = length;
      end
    end
  endtask

  // One clock of stimulus, then the model's view of that cycle.
  task automatic run_cycle(input logic clear_value, input logic valid_value, input pc_t pc_value,
                           input block_t data_value, input logic hold_value);
    logic   exp_valid0;
    logic   exp_valid1;
    pc_t    exp_pc0;
    pc_t    exp_pc1;
    instr_t exp_instr0;
    instr_t exp_instr1;
    int     used0;
    int     used1;
    int     first;
    @(posedge clock);
    clear       <= clear_value;
    fetch_valid <= valid_value;
    fetch_pc    <= pc_value;
    fetch_data  <= data_value;
    hold        <= hold_value;
    @(negedge clock);
    last_accepted = 1'b0;
    if (clear_value) begin
      model_queue.delete();
    end else if (valid_value && !model_full) begin
      last_accepted = 1'b1;
      first = realign_pending ? int'(pc_value[2:1]) : 0;
      for (int k = first; k < 4; k++) begin
        model_queue.push_back({pc_value[31:3], 3'(2 * k), data_value[16*k +: 16]});
      end
    end
    check_valid("fetch_stall", fetch_stall, !last_accepted);
    predict_slot(!clear_value && !hold_value, 0, exp_valid0, exp_pc0, exp_instr0, used0);
    predict_slot(exp_valid0, used0, exp_valid1, exp_pc1, exp_instr1, used1);
    check_valid("valid0", valid0, exp_valid0);
    check_pc("pc0", pc0, exp_pc0);
    check_instr("instr0", instr0, exp_instr0);
    check_valid("valid1", valid1, exp_valid1);
    check_pc("pc1", pc1, exp_pc1);
    check_instr("instr1", instr1, exp_instr1);
    repeat (used0 + used1) void'(model_queue.pop_front());
    model_full = model_queue.size() > threshold;  // Registered and seen next cycle.
    if (clear_value) begin
      realign_pending = 1'b1;
    end else if (last_accepted) begin
      realign_pending = 1'b0;
    end
  endtask

  task automatic drain_buffer();
    while (issue_pending()) begin
      run_cycle(1'b0, 1'b0, '0, '0, 1'b0);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("test %s finished with %0d errors", name, error_count - errors_before);
  endtask

  task automatic compressed_stream_test();
    int  errors_before;
    pc_t pc;
    errors_before = error_count;
    pc = 32'h0000_1000;
    for (int b = 0; b < 4; b++) begin
      run_cycle(1'b0, 1'b1, pc, compressed_block(pc), 1'b0);
      pc = pc + 32'd8;
    end
    drain_buffer();
    report_test("compressed_stream", errors_before);
  endtask

  task automatic mixed_stream_test();
    int     errors_before;
    pc_t    pc;
    block_t data;
    errors_before = error_count;
    run_cycle(1'b1, 1'b0, '0, '0, 1'b0);
    pc = 32'h0000_2000;
    for (int b = 0; b < 8; b++) begin
      random_block(data);
      run_cycle(1'b0, 1'b1, pc, data, 1'b0);
      pc = pc + 32'd8;
    end
    drain_buffer();
    report_test("mixed_stream", errors_before);
  endtask

  task automatic realign_test();
    int errors_before;
    errors_before = error_count;
    // A held block is flushed by the redirect.
    run_cycle(1'b0, 1'b1, 32'h0000_3000, compressed_block(32'h0000_3000), 1'b1);
    // Blocks offered during clear are dropped.
    run_cycle(1'b1, 1'b1, 32'h0000_3000, compressed_block(32'h0000_3000), 1'b0);
    run_cycle(1'b1, 1'b1, 32'h0000_3000, compressed_block(32'h0000_3000), 1'b0);
    run_cycle(1'b0, 1'b1, 32'h0000_3004, compressed_block(32'h0000_3004), 1'b0);
    check_pc("pc0", pc0, 32'h0000_3004);
    run_cycle(1'b0, 1'b1, 32'h0000_3008, compressed_block(32'h0000_3008), 1'b0);
    drain_buffer();
    report_test("realign", errors_before);
  endtask

  task automatic hold_test();
    int     errors_before;
    pc_t    pc;
    block_t data;
    errors_before = error_count;
    run_cycle(1'b1, 1'b0, '0, '0, 1'b0);
    pc = 32'h0000_4000;
    for (int b = 0; b < 3; b++) begin
      random_block(data);
      run_cycle(1'b0, 1'b1, pc, data, 1'b1);
      pc = pc + 32'd8;
    end
    run_cycle(1'b0, 1'b0, '0, '0, 1'b1);
    drain_buffer();
    report_test("hold", errors_before);
  endtask

  task automatic full_stall_test();
    int     errors_before;
    int     stall_block;
    pc_t    pc;
    block_t data;
    errors_before = error_count;
    stall_block   = -1;
    run_cycle(1'b1, 1'b0, '0, '0, 1'b0);
    pc = 32'h0000_5000;
    for (int b = 0; b < buffer_depth + 2; b++) begin
      random_block(data);  // Fresh data on a retry, so a dropped block would show.
      run_cycle(1'b0, 1'b1, pc, data, 1'b1);
      if (fetch_stall && (stall_block < 0)) begin
        stall_block = b;
      end
      if (last_accepted) begin
        pc = pc + 32'd8;
      end
    end
    if ((stall_block < 0) || (stall_block >= buffer_depth)) begin
      error_count++;
      $display("fetch_stall did not rise within %0d blocks under hold", buffer_depth);
    end
    drain_buffer();
    random_block(data);
    run_cycle(1'b0, 1'b1, pc, data, 1'b0);
    drain_buffer();
    report_test("full_stall", errors_before);
  endtask

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    clear       <= 1'b0;
    fetch_valid <= 1'b0;
    hold        <= 1'b0;
    fetch_pc    <= '0;
    fetch_data  <= '0;
    wait (reset === 1'b1);
    compressed_stream_test();
    mixed_stream_test();
    realign_test();
    hold_test();
    full_stall_test();
    $display("tests: 5, checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
  parameter int reset_cycles = 2
) (
  output logic clock,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int half_period = 10;  // 20 ns period.

  initial begin
    clock = 1'b0;
    forever #half_period clock = ~clock;
  end

  initial begin
    reset = 1'b0;  // Active low.
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b1;
  end

endmodule

`default_nettype wire
